/* Makefile */
# Verilator build and run for the matrix multiplier testbench

VERILATOR ?= verilator
TOP       ?= matmul_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG := ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST)) test/matmul_ref.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -qF -- '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/dot_product_cell.sv */
`default_nettype none

module dot_product_cell (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  logic [matmul_pkg::M*matmul_pkg::X_W-1:0] row,
  input  logic [matmul_pkg::M*matmul_pkg::Y_W-1:0] col,
  input  logic                                     start,
  output logic                                     start_ready,
  output logic [matmul_pkg::ACC_W-1:0]             acc,
  output logic                                     done,
  input  logic                                     take
);

  matmul_pkg::cell_state_t state;
  logic [matmul_pkg::CNT_W-1:0] cnt;
  logic [matmul_pkg::M*matmul_pkg::X_W-1:0] row_q;
  logic [matmul_pkg::M*matmul_pkg::Y_W-1:0] col_q;
  logic signed [matmul_pkg::X_W-1:0] x_el;
  logic signed [matmul_pkg::Y_W-1:0] y_el;
  logic signed [matmul_pkg::X_W+matmul_pkg::Y_W-1:0] prod;
  logic [matmul_pkg::ACC_W-1:0] acc_q;

  // Current element pair picked by the counter
  assign x_el = row_q[cnt*matmul_pkg::X_W +: matmul_pkg::X_W];
  assign y_el = col_q[cnt*matmul_pkg::Y_W +: matmul_pkg::Y_W];
  // Full-width signed product
  assign prod = x_el * y_el;

  assign start_ready = (state == matmul_pkg::CELL_IDLE);
  assign done = (state == matmul_pkg::CELL_DONE);
  assign acc = acc_q;

  // Cell FSM and element counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= matmul_pkg::CELL_IDLE;
      cnt <= '0;
    end else begin
      case (state)
        matmul_pkg::CELL_IDLE: begin
          if (start) begin
            state <= matmul_pkg::CELL_MAC;
          end
        end
        matmul_pkg::CELL_MAC: begin
          // Last product this edge and the counter wraps for the next job
          if (cnt == matmul_pkg::CNT_W'(matmul_pkg::M - 1)) begin
            state <= matmul_pkg::CELL_DONE;
            cnt <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        matmul_pkg::CELL_DONE: begin
          // Hold the sum until the result stage takes it
          if (take) begin
            state <= matmul_pkg::CELL_IDLE;
          end
        end
        default: state <= matmul_pkg::CELL_IDLE;
      endcase
    end
  end

  // Operand latch and accumulator
  always_ff @(posedge clk) begin
    if (state == matmul_pkg::CELL_IDLE && start) begin
      row_q <= row;
      col_q <= col;
      acc_q <= '0;
    end else if (state == matmul_pkg::CELL_MAC) begin
      // Sign-extend product into the guard bits
      acc_q <= acc_q + {{matmul_pkg::CNT_W{prod[matmul_pkg::X_W+matmul_pkg::Y_W-1]}}, prod};
    end
  end

  // The result stage only takes a finished sum
  a_take_done: assert property (@(posedge clk) disable iff (!arst_n)
    take |-> done)
    else $error("take while the sum is not finished");

  a_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
    cnt <= matmul_pkg::CNT_W'(matmul_pkg::M - 1))
    else $error("element counter past M-1");

endmodule

`default_nettype wire

/* design/matmul_pkg.sv */
`default_nettype none

package matmul_pkg;

  // Matrix dimensions, out (N x K) = X (N x M) * Y (M x K)
  localparam int N = 2;
  localparam int M = 3;
  localparam int K = 2;

  // X element format, signed
  localparam int X_W = 8;
  localparam int X_FRAC = 3;

  // Y element format, signed
  localparam int Y_W = 8;
  localparam int Y_FRAC = 3;

  // Element counter in each cell
  localparam int CNT_W = $clog2(M);

  // Accumulator holds M full products without overflow
  localparam int ACC_W = X_W + Y_W + CNT_W;
  localparam int ACC_FRAC = X_FRAC + Y_FRAC;

  // Output element format, signed
  localparam int OUT_W = 10;
  localparam int OUT_FRAC = 2;

  // Fraction bits dropped by rounding
  localparam int SHIFT = ACC_FRAC - OUT_FRAC;
  // Half an output LSB in accumulator units
  localparam int RND_HALF = 1 << (SHIFT - 1);

  // Saturation limits of the output format
  localparam int OUT_MAX = (1 << (OUT_W - 1)) - 1;
  localparam int OUT_MIN = -(1 << (OUT_W - 1));

  // X, row-major, element i*M+m
  typedef struct packed {
    logic [N*M-1:0][X_W-1:0] el;
  } x_mat_t;

  // Y, column-major, element j*M+m
  typedef struct packed {
    logic [M*K-1:0][Y_W-1:0] el;
  } y_mat_t;

  // Operand pair held by the join buffer
  typedef struct packed {
    x_mat_t x;
    y_mat_t y;
  } operand_t;

  // One raw accumulator per output element, index i*K+j
  typedef struct packed {
    logic [N*K-1:0][ACC_W-1:0] acc;
  } acc_vec_t;

  // Rounded result matrix, row-major
  typedef struct packed {
    logic [N*K-1:0][OUT_W-1:0] el;
  } out_mat_t;

  // Dot-product cell FSM
  typedef enum logic [1:0] {
    CELL_IDLE,
    CELL_MAC,
    CELL_DONE
  } cell_state_t;

endpackage

`default_nettype wire

/* design/matmul_top.sv */
`default_nettype none

module matmul_top (
  input  logic                 clk,
  input  logic                 arst_n,
  // X, row-major
  input  matmul_pkg::x_mat_t   x_data,
  input  logic                 x_valid,
  output logic                 x_ready,
  // Y, column-major
  input  matmul_pkg::y_mat_t   y_data,
  input  logic                 y_valid,
  output logic                 y_ready,
  // Result, row-major
  output matmul_pkg::out_mat_t out_data,
  output logic                 out_valid,
  input  logic                 out_ready
);

  matmul_pkg::operand_t op;
  logic op_valid;
  logic take;
  // Driven per cell from the generate loop
  wire [matmul_pkg::N*matmul_pkg::K-1:0] start_ready;
  wire [matmul_pkg::N*matmul_pkg::K-1:0] done;
  wire matmul_pkg::acc_vec_t acc_vec;

  operand_join u_join (
    .clk         (clk),
    .arst_n      (arst_n),
    .x_data      (x_data),
    .x_valid     (x_valid),
    .x_ready     (x_ready),
    .y_data      (y_data),
    .y_valid     (y_valid),
    .y_ready     (y_ready),
    .op          (op),
    .op_valid    (op_valid),
    .start_ready (start_ready)
  );

  // One cell per output element
  for (genvar i = 0; i < matmul_pkg::N; i++) begin : g_row
    for (genvar j = 0; j < matmul_pkg::K; j++) begin : g_col
      dot_product_cell u_cell (
        .clk         (clk),
        .arst_n      (arst_n),
        // Row i of X and column j of Y are both contiguous
        .row         (op.x.el[i*matmul_pkg::M +: matmul_pkg::M]),
        .col         (op.y.el[j*matmul_pkg::M +: matmul_pkg::M]),
        .start       (op_valid),
        .start_ready (start_ready[i*matmul_pkg::K+j]),
        .acc         (acc_vec.acc[i*matmul_pkg::K+j]),
        .done        (done[i*matmul_pkg::K+j]),
        .take        (take)
      );
    end
  end

  result_round u_round (
    .clk       (clk),
    .arst_n    (arst_n),
    .acc_vec   (acc_vec),
    .done      (done),
    .take      (take),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

/* design/operand_join.sv */
`default_nettype none

module operand_join (
  input  logic                              clk,
  input  logic                              arst_n,
  input  matmul_pkg::x_mat_t                x_data,
  input  logic                              x_valid,
  output logic                              x_ready,
  input  matmul_pkg::y_mat_t                y_data,
  input  logic                              y_valid,
  output logic                              y_ready,
  output matmul_pkg::operand_t              op,
  output logic                              op_valid,
  input  logic [matmul_pkg::N*matmul_pkg::K-1:0] start_ready
);

  logic load;
  logic op_ready;

  // Both inputs open only while the buffer is empty
  assign x_ready = !op_valid;
  assign y_ready = !op_valid;

  // Never take one matrix without its partner
  assign load = x_valid && y_valid && !op_valid;

  // Every cell has to be idle before the broadcast
  assign op_ready = &start_ready;

  // Buffer occupancy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_valid <= 1'b0;
    end else if (load) begin
      op_valid <= 1'b1;
    end else if (op_valid && op_ready) begin
      op_valid <= 1'b0;
    end
  end

  // Operand pair register
  always_ff @(posedge clk) begin
    if (load) begin
      op.x <= x_data;
      op.y <= y_data;
    end
  end

  // Held operands stay put until the cells start
  a_op_hold: assert property (@(posedge clk) disable iff (!arst_n)
    op_valid && !op_ready |=> op_valid && $stable(op))
    else $error("operand buffer changed before broadcast");

endmodule

`default_nettype wire

/* design/result_round.sv */
`default_nettype none

module result_round (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  matmul_pkg::acc_vec_t                   acc_vec,
  input  logic [matmul_pkg::N*matmul_pkg::K-1:0] done,
  output logic                                   take,
  output matmul_pkg::out_mat_t                   out_data,
  output logic                                   out_valid,
  input  logic                                   out_ready
);

  matmul_pkg::out_mat_t rounded;

  // Round half-up, then clamp to the signed output range
  function automatic logic [matmul_pkg::OUT_W-1:0] round_sat(
    input logic [matmul_pkg::ACC_W-1:0] a
  );
    logic signed [matmul_pkg::ACC_W:0] biased;
    logic signed [matmul_pkg::ACC_W-matmul_pkg::SHIFT:0] q;
    // One guard bit so the bias cannot wrap
    biased = $signed({a[matmul_pkg::ACC_W-1], a})
           + $signed((matmul_pkg::ACC_W+1)'(matmul_pkg::RND_HALF));
    // Arithmetic shift floors, so ties go toward +inf
    q = biased[matmul_pkg::ACC_W:matmul_pkg::SHIFT];
    if (q > matmul_pkg::OUT_MAX) begin
      return matmul_pkg::OUT_W'(matmul_pkg::OUT_MAX);
    end else if (q < matmul_pkg::OUT_MIN) begin
      return matmul_pkg::OUT_W'(matmul_pkg::OUT_MIN);
    end
    return q[matmul_pkg::OUT_W-1:0];
  endfunction

  // Per-element rounding of the raw sums
  always_comb begin
    for (int i = 0; i < matmul_pkg::N * matmul_pkg::K; i++) begin
      rounded.el[i] = round_sat(acc_vec.acc[i]);
    end
  end

  // All cells finished and output slot free or draining now
  assign take = (&done) && (!out_valid || out_ready);

  // Output valid flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Result matrix register
  always_ff @(posedge clk) begin
    if (take) begin
      out_data <= rounded;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("output changed while stalled");

endmodule

`default_nettype wire

/* project.f */
+incdir+test
design/matmul_pkg.sv
design/operand_join.sv
design/dot_product_cell.sv
design/result_round.sv
design/matmul_top.sv
test/matmul_tb.sv

/* test/matmul_ref.svh */
`ifndef MATMUL_REF_SVH
`define MATMUL_REF_SVH

// Round half-up to the output fraction, then clamp to the signed output range
function automatic logic [matmul_pkg::OUT_W-1:0] model_round(input longint sum);
  longint half;
  longint hi;
  longint lo;
  longint q;
  half = longint'(1) <<< (matmul_pkg::SHIFT - 1);
  hi = (longint'(1) <<< (matmul_pkg::OUT_W - 1)) - 1;
  lo = -(longint'(1) <<< (matmul_pkg::OUT_W - 1));
  // Bias by half an output LSB, arithmetic shift floors
  q = (sum + half) >>> matmul_pkg::SHIFT;
  if (q > hi) begin
    q = hi;
  end else if (q < lo) begin
    q = lo;
  end
  return q[matmul_pkg::OUT_W-1:0];
endfunction

// Full product, X row-major, Y column-major, result row-major
function automatic matmul_pkg::out_mat_t model_matmul(input matmul_pkg::x_mat_t x,
                                                      input matmul_pkg::y_mat_t y);
  matmul_pkg::out_mat_t r;
  longint sum;
  for (int i = 0; i < matmul_pkg::N; i++) begin
    for (int j = 0; j < matmul_pkg::K; j++) begin
      sum = 0;
      for (int m = 0; m < matmul_pkg::M; m++) begin
        sum += longint'($signed(x.el[i*matmul_pkg::M+m]))
             * longint'($signed(y.el[j*matmul_pkg::M+m]));
      end
      r.el[i*matmul_pkg::K+j] = model_round(sum);
    end
  end
  return r;
endfunction

`endif

/* test/matmul_tb.sv */
`default_nettype none

module matmul_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED = 32'h449f;
  localparam int SB_DEPTH = 64;
  localparam int WAIT_LIMIT = 400;

  logic clk = 1'b0;
  logic arst_n = 1'b0;
  matmul_pkg::x_mat_t x_data = '0;
  logic x_valid = 1'b0;
  logic x_ready;
  matmul_pkg::y_mat_t y_data = '0;
  logic y_valid = 1'b0;
  logic y_ready;
  matmul_pkg::out_mat_t out_data;
  logic out_valid;
  logic out_ready = 1'b0;

  // Scoreboard, circular store of expected matrices
  matmul_pkg::out_mat_t exp_mem [SB_DEPTH];
  matmul_pkg::out_mat_t exp_head;
  logic sb_empty;
  int wr_cnt = 0;
  int rd_cnt = 0;
  int errors = 0;
  int tests = 0;
  logic timed_out = 1'b0;
  logic ready_random = 1'b0;
  logic [31:0] rng = SEED;
  logic [31:0] ready_rng = ~SEED;

  `include "matmul_ref.svh"

  matmul_top DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .x_data    (x_data),
    .x_valid   (x_valid),
    .x_ready   (x_ready),
    .y_data    (y_data),
    .y_valid   (y_valid),
    .y_ready   (y_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = lcg_step(rng);
    return rng;
  endfunction

  function automatic matmul_pkg::x_mat_t rand_x();
    matmul_pkg::x_mat_t x;
    logic [31:0] r;
    for (int k = 0; k < matmul_pkg::N * matmul_pkg::M; k++) begin
      r = next_rand();
      x.el[k] = r[31 -: matmul_pkg::X_W];
    end
    return x;
  endfunction

  function automatic matmul_pkg::y_mat_t rand_y();
    matmul_pkg::y_mat_t y;
    logic [31:0] r;
    for (int k = 0; k < matmul_pkg::M * matmul_pkg::K; k++) begin
      r = next_rand();
      y.el[k] = r[31 -: matmul_pkg::Y_W];
    end
    return y;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  // Expected result queued on the paired input handshake, popped on output transfer
  always @(posedge clk) begin
    if (x_valid && x_ready && y_valid && y_ready) begin
      exp_mem[wr_cnt % SB_DEPTH] <= model_matmul(x_data, y_data);
      wr_cnt <= wr_cnt + 1;
    end
    if (out_valid && out_ready && !sb_empty) begin
      rd_cnt <= rd_cnt + 1;
    end
  end

  assign exp_head = exp_mem[rd_cnt % SB_DEPTH];
  assign sb_empty = (wr_cnt == rd_cnt);

  // Output back-pressure, own random stream
  always @(posedge clk) begin
    ready_rng = lcg_step(ready_rng);
    out_ready <= ready_random ? ready_rng[20] : 1'b1;
  end

  a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid && x_ready && y_ready)
    else report_error("outputs not idle during reset");

  a_result: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && out_ready && !sb_empty |-> out_data == exp_head)
    else report_error("out_data differs from the model product");

  // A result with nothing queued means a duplicate or an invented output
  a_no_extra: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && out_ready |-> !sb_empty)
    else report_error("output transfer with no expected result pending");

  a_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else report_error("stalled output changed");

  a_ready_pair: assert property (@(posedge clk) disable iff (!arst_n) x_ready == y_ready)
    else report_error("x_ready and y_ready differ");

  // Lone X must not load the buffer
  a_lone_x: assert property (@(posedge clk) disable iff (!arst_n)
    x_valid && x_ready && !y_valid |=> x_ready)
    else report_error("join consumed X without Y");

  task automatic send_pair(input matmul_pkg::x_mat_t x, input matmul_pkg::y_mat_t y,
                           input int x_lead);
    int waited;
    logic accepted;
    waited = 0;
    accepted = 1'b0;
    x_data <= x;
    x_valid <= 1'b1;
    repeat (x_lead) @(posedge clk);
    y_data <= y;
    y_valid <= 1'b1;
    while (!accepted && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
      accepted = x_ready && y_ready;
    end
    x_valid <= 1'b0;
    y_valid <= 1'b0;
    if (!accepted) begin
      $display("timeout: x_ready and y_ready never rose for an input pair");
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!sb_empty && waited < WAIT_LIMIT);
    if (!sb_empty) begin
      $display("timeout: out_valid never came for %0d pending results", wr_cnt - rd_cnt);
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    tests++;
    if (errors == errs_at_start && !timed_out) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: errors seen", tests, name);
    end
  endtask

  task automatic run_tests();
    int e;
    matmul_pkg::x_mat_t x;
    matmul_pkg::y_mat_t y;
    logic [31:0] r;
    // Reset state right after release
    e = errors;
    @(negedge clk);
    assert (!out_valid && x_ready && y_ready)
      else report_error("outputs not idle after reset");
    @(posedge clk);
    end_test("reset state", e);
    e = errors;
    send_pair(rand_x(), rand_y(), 0);
    if (!timed_out) wait_drain();
    end_test("single product", e);
    // X waits four cycles for its partner
    e = errors;
    if (!timed_out) send_pair(rand_x(), rand_y(), 4);
    if (!timed_out) wait_drain();
    end_test("input skew", e);
    e = errors;
    ready_random <= 1'b1;
    for (int p = 0; p < 50 && !timed_out; p++) begin
      r = next_rand();
      repeat (r[25:24]) @(posedge clk);
      send_pair(rand_x(), rand_y(), int'(r[27:26]) % 2);
    end
    if (!timed_out) wait_drain();
    ready_random <= 1'b0;
    end_test("random stream", e);
    // Max times max, min times min, max times min
    e = errors;
    for (int k = 0; k < 3 && !timed_out; k++) begin
      for (int n = 0; n < matmul_pkg::N * matmul_pkg::M; n++) begin
        x.el[n] = (k == 1) ? 8'h80 : 8'h7f;
      end
      for (int n = 0; n < matmul_pkg::M * matmul_pkg::K; n++) begin
        y.el[n] = (k == 0) ? 8'h7f : 8'h80;
      end
      send_pair(x, y, 0);
    end
    if (!timed_out) wait_drain();
    end_test("saturation", e);
    // Sums of +-8 and +-24, exactly half an output LSB off the grid
    e = errors;
    x = '0;
    y = '0;
    x.el[0] = 8'sd1;
    x.el[matmul_pkg::M] = -8'sd1;
    y.el[0] = 8'sd8;
    y.el[matmul_pkg::M] = 8'sd24;
    if (!timed_out) send_pair(x, y, 0);
    if (!timed_out) wait_drain();
    end_test("rounding ties", e);
  endtask

  initial begin
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    run_tests();
    $display("tests %0d, results checked %0d, errors %0d", tests, rd_cnt, errors);
    if (errors == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
